// File: include/shim_config.svh
`ifndef SHIM_CONFIG_SVH
`define SHIM_CONFIG_SVH

// ==================================================
// Sizing of the memory-request shim
// ==================================================

// Word address into the on-chip memory
`define SHIM_ADDR_BITS 6

// Width of one data word
`define SHIM_DATA_BITS 32

// Request tag carried through to the response
`define SHIM_TAG_BITS 4

// Number of entries in the lockstep request buffer
`define SHIM_FIFO_DEPTH 8

// Almost-full rises when the free slots drop to this value or below
`define SHIM_ALM_FULL_THRESHOLD 2

`endif

// File: hdl/shim_pkg.sv
`default_nettype none

`include "shim_config.svh"

package shim_pkg;

    // ==================================================
    // Request channels from the client
    // ==================================================

    // Channel 0 carries read requests
    typedef struct packed {
        logic                        valid;
        logic [`SHIM_ADDR_BITS-1:0]  addr;
        logic [`SHIM_TAG_BITS-1:0]   tag;
    } c0_tx_t;

    // Channel 1 carries write requests with their data
    typedef struct packed {
        logic                        valid;
        logic [`SHIM_ADDR_BITS-1:0]  addr;
        logic [`SHIM_DATA_BITS-1:0]  data;
        logic [`SHIM_TAG_BITS-1:0]   tag;
    } c1_tx_t;

    // One buffer entry, channel 0 first and channel 1 second
    typedef struct packed {
        c0_tx_t c0;
        c1_tx_t c1;
    } tx_pair_t;

    // ==================================================
    // Internal pipeline
    // ==================================================

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } mem_op_e;

    // A single memory operation issued by decode
    typedef struct packed {
        logic                        valid;
        mem_op_e                     op;
        logic [`SHIM_ADDR_BITS-1:0]  addr;
        logic [`SHIM_DATA_BITS-1:0]  data;
        logic [`SHIM_TAG_BITS-1:0]   tag;
    } mem_op_t;

    // Outcome of one operation, data is only meaningful for reads
    typedef struct packed {
        logic                        valid;
        mem_op_e                     op;
        logic [`SHIM_TAG_BITS-1:0]   tag;
        logic [`SHIM_DATA_BITS-1:0]  data;
    } exec_rsp_t;

    // Read response on channel 0
    typedef struct packed {
        logic                        valid;
        logic [`SHIM_TAG_BITS-1:0]   tag;
        logic [`SHIM_DATA_BITS-1:0]  data;
    } c0_rx_t;

    // Write acknowledgement on channel 1
    typedef struct packed {
        logic                        valid;
        logic [`SHIM_TAG_BITS-1:0]   tag;
    } c1_rx_t;

    typedef enum logic {
        DEC_FIRST,
        DEC_SECOND
    } decode_state_e;

endpackage

`default_nettype wire

// File: hdl/shim_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "shim_config.svh"

module shim_fifo
#(
    parameter int N_DATA_BITS = 32,
    parameter int N_ENTRIES   = `SHIM_FIFO_DEPTH,
    parameter int THRESHOLD   = `SHIM_ALM_FULL_THRESHOLD
)
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [N_DATA_BITS-1:0] enq_data,
    input  wire logic                   enq_en,
    output logic                        not_full,
    output logic                        almost_full,
    output logic      [N_DATA_BITS-1:0] first,
    input  wire logic                   deq_en,
    output logic                        not_empty
);

    localparam int PTR_BITS = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;
    localparam int CNT_BITS = $clog2(N_ENTRIES + 1);

    logic [N_DATA_BITS-1:0] mem [0:N_ENTRIES-1];
    logic [PTR_BITS-1:0]    wr_ptr;
    logic [PTR_BITS-1:0]    rd_ptr;
    logic [CNT_BITS-1:0]    count;

    // Status flags come straight from the registered occupancy
    assign not_full    = (count != CNT_BITS'(N_ENTRIES));
    assign not_empty   = (count != '0);
    assign almost_full = ((CNT_BITS'(N_ENTRIES) - count) <= CNT_BITS'(THRESHOLD));

    // Show-ahead head, visible in the cycle after it was written
    assign first = mem[rd_ptr];

    // Storage array holds payload only
    always_ff @(posedge clk)
    begin
        if (enq_en && not_full)
            mem[wr_ptr] <= enq_data;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // Pointers wrap explicitly so the depth need not be a power of two
            if (enq_en && not_full)
                wr_ptr <= (wr_ptr == PTR_BITS'(N_ENTRIES - 1)) ? '0 : wr_ptr + 1'b1;
            if (deq_en && not_empty)
                rd_ptr <= (rd_ptr == PTR_BITS'(N_ENTRIES - 1)) ? '0 : rd_ptr + 1'b1;
            // Simultaneous enqueue and dequeue leave the count unchanged
            case ({enq_en && not_full, deq_en && not_empty})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The producer must honour almost-full, so a full FIFO never sees a push
    a_no_enq_full: assert property (@(posedge clk) disable iff (!rst_n) enq_en |-> not_full);
    // The consumer only pops an entry it has seen at the head
    a_no_deq_empty: assert property (@(posedge clk) disable iff (!rst_n) deq_en |-> not_empty);

endmodule

`default_nettype wire

// File: hdl/lockstep_tx_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "shim_config.svh"

module lockstep_tx_buffer
    import shim_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire c0_tx_t   c0_tx,
    input  wire c1_tx_t   c1_tx,
    output logic          tx_alm_full,
    output tx_pair_t      head,
    input  wire logic     deq
);

    // ==================================================
    // Both channels share one entry so a read and a
    // write from the same cycle stay in order
    // ==================================================

    localparam int TX_BITS = $bits(tx_pair_t);

    logic               enq_en;
    logic               not_empty;
    logic [TX_BITS-1:0] first;
    tx_pair_t           head_raw;

    // Any valid channel is enough to claim a slot
    assign enq_en = c0_tx.valid || c1_tx.valid;

    // Field order of the FIFO word matches tx_pair_t
    assign head_raw = first;

    always_comb
    begin
        head = head_raw;
        // Stale valids in an empty FIFO must not look like requests
        head.c0.valid = head_raw.c0.valid && not_empty;
        head.c1.valid = head_raw.c1.valid && not_empty;
    end

    shim_fifo
    #(
        .N_DATA_BITS (TX_BITS),
        .N_ENTRIES   (`SHIM_FIFO_DEPTH),
        .THRESHOLD   (`SHIM_ALM_FULL_THRESHOLD)
    )
    tx_fifo
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .enq_data    ({c0_tx, c1_tx}),
        .enq_en      (enq_en),
        .not_full    (),
        .almost_full (tx_alm_full),
        .first       (first),
        .deq_en      (deq),
        .not_empty   (not_empty)
    );

endmodule

`default_nettype wire

// File: hdl/tx_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "shim_config.svh"

module tx_decode
    import shim_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire tx_pair_t head,
    output logic          deq,
    output mem_op_t       op
);

    decode_state_e state;
    decode_state_e state_next;
    mem_op_t       op_next;
    logic          any_valid;
    logic          both_valid;

    assign any_valid  = head.c0.valid || head.c1.valid;
    assign both_valid = head.c0.valid && head.c1.valid;

    // The entry leaves the buffer with its last operation
    assign deq = any_valid && (!both_valid || (state == DEC_SECOND));

    // ==================================================
    // Operation select, write ahead of read
    // ==================================================
    always_comb
    begin
        op_next = '0;
        if ((state == DEC_FIRST) && head.c1.valid)
        begin
            op_next.valid = 1'b1;
            op_next.op    = OP_WRITE;
            op_next.addr  = head.c1.addr;
            op_next.data  = head.c1.data;
            op_next.tag   = head.c1.tag;
        end
        else if (head.c0.valid)
        begin
            // Reached for read-only entries and for the second half of a pair
            op_next.valid = 1'b1;
            op_next.op    = OP_READ;
            op_next.addr  = head.c0.addr;
            op_next.tag   = head.c0.tag;
        end
    end

    // A pair holds the head for one more cycle
    assign state_next = ((state == DEC_FIRST) && both_valid) ? DEC_SECOND : DEC_FIRST;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= DEC_FIRST;
        else
            state <= state_next;
    end

    always_ff @(posedge clk)
    begin
        op <= op_next;
        if (!rst_n)
            op.valid <= 1'b0;
    end

    a_deq_has_req: assert property (@(posedge clk) disable iff (!rst_n) deq |-> any_valid);
    // The buffer must keep the pair at its head until the read half is issued
    a_pair_held: assert property (@(posedge clk) disable iff (!rst_n)
        (state == DEC_SECOND) |-> both_valid);

endmodule

`default_nettype wire

// File: hdl/mem_execute.sv
`timescale 1ns/1ns
`default_nettype none

`include "shim_config.svh"

module mem_execute
    import shim_pkg::*;
(
    input  wire logic    clk,
    input  wire mem_op_t op,
    output exec_rsp_t    rsp,
    input  wire logic    rst_n
);

    localparam int N_WORDS = 2 ** `SHIM_ADDR_BITS;

    // ==================================================
    // Single-port word memory
    // ==================================================

    logic [`SHIM_DATA_BITS-1:0] mem [0:N_WORDS-1];

    // Contents are whatever the client last wrote
    always_ff @(posedge clk)
    begin
        if (op.valid && (op.op == OP_WRITE))
            mem[op.addr] <= op.data;
    end

    // One register stage for data, op and tag
    always_ff @(posedge clk)
    begin
        // Read port sees the old word, only reads use the result
        rsp.data <= mem[op.addr];
        rsp.op   <= op.op;
        rsp.tag  <= op.tag;
        rsp.valid <= op.valid;
        if (!rst_n)
            rsp.valid <= 1'b0;
    end

    // An unknown address would corrupt or read an undefined word
    a_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
        op.valid |-> !$isunknown(op.addr));

endmodule

`default_nettype wire

// File: hdl/rx_result.sv
`timescale 1ns/1ns
`default_nettype none

`include "shim_config.svh"

module rx_result
    import shim_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire exec_rsp_t rsp,
    output c0_rx_t         c0_rx,
    output c1_rx_t         c1_rx
);

    // Route each outcome by op, payload always follows the input
    always_ff @(posedge clk)
    begin
        c0_rx.valid <= rsp.valid && (rsp.op == OP_READ);
        c0_rx.tag   <= rsp.tag;
        c0_rx.data  <= rsp.data;
        c1_rx.valid <= rsp.valid && (rsp.op == OP_WRITE);
        c1_rx.tag   <= rsp.tag;
        if (!rst_n)
        begin
            c0_rx.valid <= 1'b0;
            c1_rx.valid <= 1'b0;
        end
    end

    a_one_channel: assert property (@(posedge clk) disable iff (!rst_n)
        !(c0_rx.valid && c1_rx.valid));

endmodule

`default_nettype wire

// File: hdl/shim_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "shim_config.svh"

module shim_top
    import shim_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire c0_tx_t c0_tx,
    input  wire c1_tx_t c1_tx,
    output logic        tx_alm_full,
    output c0_rx_t      c0_rx,
    output c1_rx_t      c1_rx
);

    // ==================================================
    // Buffer, decode, execute and result in a chain
    // ==================================================

    tx_pair_t  head;
    logic      deq;
    mem_op_t   op;
    exec_rsp_t rsp;

    lockstep_tx_buffer u_buffer
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .c0_tx       (c0_tx),
        .c1_tx       (c1_tx),
        .tx_alm_full (tx_alm_full),
        .head        (head),
        .deq         (deq)
    );

    tx_decode u_decode (.clk(clk), .rst_n(rst_n), .head(head), .deq(deq), .op(op));

    mem_execute u_execute (.clk(clk), .op(op), .rsp(rsp), .rst_n(rst_n));

    // Responses leave in the order decode issued the operations
    rx_result u_result (.clk(clk), .rst_n(rst_n), .rsp(rsp), .c0_rx(c0_rx), .c1_rx(c1_rx));

endmodule

`default_nettype wire

// File: sim/shim_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "shim_config.svh"

module shim_tb
    import shim_pkg::*;
();

    localparam int ADDR_BITS   = `SHIM_ADDR_BITS;
    localparam int N_WORDS     = 2 ** `SHIM_ADDR_BITS;
    localparam int N_READBACK  = 16;
    localparam int N_PAIRS     = 6;
    localparam int N_BURST     = 16;
    localparam int N_RANDOM    = 80;
    // Every request of every test, pairs and random cycles counted at two
    localparam int MAX_REQUESTS = N_WORDS + N_READBACK + 4 * N_PAIRS + 2 * N_BURST
                                  + 2 * N_RANDOM;
    localparam int CYCLE_LIMIT  = 40 * MAX_REQUESTS + 200;

    // One expected response, a read carries data and an acknowledgement only a tag
    typedef struct packed {
        logic                        is_read;
        logic [`SHIM_TAG_BITS-1:0]   tag;
        logic [`SHIM_DATA_BITS-1:0]  data;
    } exp_rsp_t;

    logic   clk = 1'b0;
    logic   rst_n;
    c0_tx_t c0_tx;
    c1_tx_t c1_tx;
    logic   tx_alm_full;
    c0_rx_t c0_rx;
    c1_rx_t c1_rx;

    logic [31:0]                seed = 32'h5c25_b87e;
    logic [`SHIM_DATA_BITS-1:0] ref_mem [0:N_WORDS-1];
    exp_rsp_t                   exp_q [$];
    int                         fifo_len_q [$];
    int                         head_done = 0;
    int                         pend_len = 0;
    logic                       exp_alm = 1'b0;
    logic                       alm_seen = 1'b0;
    int                         err_count = 0;
    int                         n_pass = 0;
    int                         n_fail = 0;
    int                         cycle_count = 0;

    shim_top UUT
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .c0_tx       (c0_tx),
        .c1_tx       (c1_tx),
        .tx_alm_full (tx_alm_full),
        .c0_rx       (c0_rx),
        .c1_rx       (c1_rx)
    );

    always #50 clk = ~clk;

    // ==================================================
    // Random values and request builders
    // ==================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        seed = xorshift32(seed);
        return seed;
    endfunction

    function automatic logic [ADDR_BITS-1:0] rand_addr();
        logic [31:0] r;
        r = next_rand();
        return r[ADDR_BITS-1:0];
    endfunction

    function automatic c0_tx_t read_req(input logic [ADDR_BITS-1:0] addr);
        logic [31:0] r;
        r = next_rand();
        return '{valid: 1'b1, addr: addr, tag: r[`SHIM_TAG_BITS-1:0]};
    endfunction

    function automatic c1_tx_t write_req(input logic [ADDR_BITS-1:0] addr);
        logic [31:0] r;
        r = next_rand();
        return '{valid: 1'b1, addr: addr, data: `SHIM_DATA_BITS'(next_rand()),
                 tag: r[`SHIM_TAG_BITS-1:0]};
    endfunction

    // ==================================================
    // Checks typed to the DUT outputs
    // ==================================================

    task automatic check_c0_rx(input c0_rx_t got, input c0_rx_t want);
        if (got.valid !== want.valid)
        begin
            $display("[FAIL] c0_rx.valid: got %h expected %h", got.valid, want.valid);
            err_count++;
        end
        else if (want.valid && (got.tag !== want.tag))
        begin
            $display("[FAIL] c0_rx.tag: got %h expected %h", got.tag, want.tag);
            err_count++;
        end
        else if (want.valid && (got.data !== want.data))
        begin
            $display("[FAIL] c0_rx.data: got %h expected %h", got.data, want.data);
            err_count++;
        end
    endtask

    task automatic check_c1_rx(input c1_rx_t got, input c1_rx_t want);
        if (got.valid !== want.valid)
        begin
            $display("[FAIL] c1_rx.valid: got %h expected %h", got.valid, want.valid);
            err_count++;
        end
        else if (want.valid && (got.tag !== want.tag))
        begin
            $display("[FAIL] c1_rx.tag: got %h expected %h", got.tag, want.tag);
            err_count++;
        end
    endtask

    task automatic check_alm_full(input logic got, input logic want);
        if (got !== want)
        begin
            $display("[FAIL] tx_alm_full: got %h expected %h", got, want);
            err_count++;
        end
    endtask

    // ==================================================
    // Driving and the buffer occupancy model
    // ==================================================

    // One clock of stimulus, the DUT takes it at the following edge
    task automatic drive_cycle(input c0_tx_t c0, input c1_tx_t c1);
        @(posedge clk);
        c0_tx <= c0;
        c1_tx <= c1;
        // Decode spends one cycle per operation on the head entry, then dequeues it
        if (fifo_len_q.size() > 0)
        begin
            head_done++;
            if (head_done == fifo_len_q[0])
            begin
                fifo_len_q.delete(0);
                head_done = 0;
            end
        end
        // The entry driven one cycle ago lands in the buffer at this edge
        if (pend_len != 0)
            fifo_len_q.push_back(pend_len);
        pend_len = (c0.valid && c1.valid) ? 2 : ((c0.valid || c1.valid) ? 1 : 0);
        // Flag is up once the buffer holds depth minus threshold entries
        exp_alm = (fifo_len_q.size() >= (`SHIM_FIFO_DEPTH - `SHIM_ALM_FULL_THRESHOLD));
        // Within an entry the write is performed before the read
        if (c1.valid)
        begin
            ref_mem[c1.addr] = c1.data;
            exp_q.push_back('{is_read: 1'b0, tag: c1.tag, data: '0});
        end
        if (c0.valid)
            exp_q.push_back('{is_read: 1'b1, tag: c0.tag, data: ref_mem[c0.addr]});
    endtask

    task automatic issue(input c0_tx_t c0, input c1_tx_t c1);
        // Client holds off while the buffer reports almost full
        while (exp_alm)
            drive_cycle('0, '0);
        drive_cycle(c0, c1);
    endtask

    task automatic wait_drained();
        while (exp_q.size() > 0)
            drive_cycle('0, '0);
    endtask

    task automatic report_test(input string name, input int start_errs);
        if (err_count == start_errs)
        begin
            $display("%s: PASS", name);
            n_pass++;
        end
        else
        begin
            $display("%s: FAIL with %0d errors", name, err_count - start_errs);
            n_fail++;
        end
    endtask

    // Outputs are sampled half a cycle after the edge that set them
    always @(negedge clk)
    begin
        exp_rsp_t e;
        if (rst_n)
        begin
            check_alm_full(tx_alm_full, exp_alm);
            if (tx_alm_full === 1'b1)
                alm_seen = 1'b1;
            if (c0_rx.valid || c1_rx.valid)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("A response strobe arrived with no request outstanding");
                    err_count++;
                end
                else
                begin
                    e = exp_q.pop_front();
                    if (e.is_read != c0_rx.valid)
                    begin
                        $display("A response arrived on the wrong channel, tag %h", e.tag);
                        err_count++;
                    end
                    else if (e.is_read)
                        check_c0_rx(c0_rx, '{valid: 1'b1, tag: e.tag, data: e.data});
                    else
                        check_c1_rx(c1_rx, '{valid: 1'b1, tag: e.tag});
                end
            end
        end
    end

    // ==================================================
    // Directed tests
    // ==================================================

    task automatic reset_state();
        int start_errs = err_count;
        repeat (3)
        begin
            @(negedge clk);
            check_c0_rx(c0_rx, '0);
            check_c1_rx(c1_rx, '0);
            check_alm_full(tx_alm_full, 1'b0);
        end
        report_test("reset state", start_errs);
    endtask

    // Fills every word so later reads never see an unwritten location
    task automatic write_then_read();
        int start_errs = err_count;
        for (int a = 0; a < N_WORDS; a++)
            issue('0, write_req(ADDR_BITS'(a)));
        for (int i = 0; i < N_READBACK; i++)
            issue(read_req(rand_addr()), '0);
        wait_drained();
        report_test("write then read", start_errs);
    endtask

    task automatic same_cycle_pair();
        int                   start_errs = err_count;
        logic [ADDR_BITS-1:0] a;
        for (int i = 0; i < N_PAIRS; i++)
        begin
            a = rand_addr();
            issue(read_req(a), write_req(a));
        end
        wait_drained();
        report_test("same-cycle pair", start_errs);
    endtask

    task automatic separate_channels();
        int                   start_errs = err_count;
        logic [ADDR_BITS-1:0] a;
        for (int i = 0; i < N_PAIRS; i++)
        begin
            a = rand_addr();
            issue(read_req(a), write_req(a + 1'b1));
        end
        wait_drained();
        report_test("separate channels", start_errs);
    endtask

    // Pairs drain at half the enqueue rate, so the buffer fills up
    task automatic almost_full_burst();
        int start_errs = err_count;
        alm_seen = 1'b0;
        for (int i = 0; i < N_BURST; i++)
            issue(read_req(rand_addr()), write_req(rand_addr()));
        wait_drained();
        if (!alm_seen)
        begin
            $display("tx_alm_full never rose during the paired burst");
            err_count++;
        end
        report_test("almost-full burst", start_errs);
    endtask

    task automatic random_mix();
        int          start_errs = err_count;
        logic [31:0] r;
        for (int i = 0; i < N_RANDOM; i++)
        begin
            r = next_rand();
            case (r[1:0])
                2'd0:    issue(read_req(rand_addr()), '0);
                2'd1:    issue('0, write_req(rand_addr()));
                default: issue(read_req(rand_addr()), write_req(rand_addr()));
            endcase
            repeat (r[3:2])
                drive_cycle('0, '0);
        end
        wait_drained();
        report_test("random mix", start_errs);
    endtask

    initial
    begin
        rst_n <= 1'b0;
        c0_tx <= '0;
        c1_tx <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        reset_state();
        write_then_read();
        same_cycle_pair();
        separate_channels();
        almost_full_burst();
        random_mix();
        $display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
        if ((n_fail == 0) && (err_count == 0))
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // Guard against a stalled pipeline
    initial
    begin
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles with %0d responses outstanding",
                 cycle_count, exp_q.size());
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
hdl/shim_pkg.sv
hdl/shim_fifo.sv
hdl/lockstep_tx_buffer.sv
hdl/tx_decode.sv
hdl/mem_execute.sv
hdl/rx_result.sv
hdl/shim_top.sv
sim/shim_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module shim_tb -o shim_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/shim_tb_sim 2>&1 | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "Simulation exited with an error"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0
